/* sim/mdp_stimulus.txt */
# columns: test, op (0 idle, 1 update, 2 read, 3 read and update), pc38, fetch index,
# asid, update byte, expected response after the cycle; all but test and op in hex
# reset value holds, cleared set reads zero
1 0 0000000000 00 000 00 0000000000000000
1 2 0000000000 00 000 00 0000000000000000
# single lane updates, other lanes kept
2 1 0000000093 00 005 a5 0000000000000000
2 2 0000000000 12 005 00 00000000a5000000
2 1 0000000096 00 005 3c 00000000a5000000
2 2 0000000000 12 005 00 003c0000a5000000
2 1 0000000093 00 005 5a 003c0000a5000000
2 2 0000000000 12 005 00 003c00005a000000
# all eight lanes of one set, upper pc bits ignored
3 1 3f00000200 00 021 11 003c00005a000000
3 1 0000000201 00 021 22 003c00005a000000
3 1 0000000202 00 021 33 003c00005a000000
3 1 0000000203 00 021 44 003c00005a000000
3 1 0000000204 00 021 55 003c00005a000000
3 1 0000000205 00 021 66 003c00005a000000
3 1 0000000206 00 021 77 003c00005a000000
3 1 2a00100207 00 021 88 003c00005a000000
3 2 0000000000 40 021 00 8877665544332211
# asid hash, bit 8 aliases, low bits select other sets
4 2 0000000000 40 121 00 8877665544332211
4 2 0000000000 40 022 00 0000000000000000
4 1 0000000205 00 022 e7 0000000000000000
4 2 0000000000 40 022 00 0000e70000000000
4 2 0000000000 43 021 00 0000e70000000000
4 1 0000000201 00 121 9d 0000e70000000000
4 2 0000000000 40 021 00 8877665544339d11
# read and update in one cycle
5 3 0000000203 40 021 c4 8877665544339d11
5 2 0000000000 40 021 00 88776655c4339d11
5 3 0000000320 12 005 01 003c00005a000000
5 2 0000000000 40 021 00 88776655c4339d01
# response holds while updates continue
6 2 0000000000 12 005 00 003c00005a000000
6 1 0000000090 00 005 ff 003c00005a000000
6 0 0000000000 00 000 00 003c00005a000000
6 1 0000000093 00 005 00 003c00005a000000
6 2 0000000000 12 005 00 003c0000000000ff

/* sources.f */
design/corep_pkg.sv
design/bram_1rport_1wport.sv
design/mdpt.sv
design/mdp_predictor.sv
sim/mdpt_properties.sv
sim/mdp_predictor_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= mdp_predictor_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

/* sim/mdp_predictor_tb.sv */
// predictor testbench with clock, reset, file stimulus, reference model, checks and watchdog

module mdp_predictor_tb;

    import corep::*;

    localparam string STIM_FILE    = "sim/mdp_stimulus.txt";
    localparam int    RESET_CYCLES = 16;
    localparam int    CLEAR_CYCLES = MDPT_SETS * FETCH_LANES;
    localparam int    RAND_ROUNDS  = 32;

    // opcodes of the stimulus file
    localparam int OP_IDLE   = 0;
    localparam int OP_UPDATE = 1;
    localparam int OP_READ   = 2;
    localparam int OP_BOTH   = 3;

    logic       CLK;
    logic       rst;
    logic       read_req_valid;
    fetch_idx_t read_req_fetch_idx;
    asid_t      read_req_asid;
    mdpt_set_t  read_resp_mdp_by_lane;
    logic       update_valid;
    pc38_t      update_pc38;
    asid_t      update_asid;
    mdp_t       update_mdp;

    mdp_predictor i_mdp_predictor (
        .CLK                   (CLK),
        .rst                   (rst),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_idx    (read_req_fetch_idx),
        .read_req_asid         (read_req_asid),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (update_valid),
        .update_pc38           (update_pc38),
        .update_asid           (update_asid),
        .update_mdp            (update_mdp)
    );

    // ----------------------------------------------------------------------
    // reference model and stimulus storage

    logic [63:0] ref_table [MDPT_SETS];
    logic [63:0] ref_resp;

    int         stim_test [$];
    int         stim_op [$];
    pc38_t      stim_pc [$];
    fetch_idx_t stim_fetch_idx [$];
    asid_t      stim_asid [$];
    mdp_t       stim_mdp [$];
    mdpt_set_t  stim_expected [$];

    int          line_count;
    logic        stim_loaded = 1'b0;
    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;
    int          test_errors_start;
    logic [31:0] lfsr_state;

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // helpers

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] hashed_set(input logic [7:0] fetch_idx, input logic [8:0] asid);
        return fetch_idx ^ asid[7:0];
    endfunction

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s: got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name);
        int errors;
        errors = error_count - test_errors_start;
        test_count++;
        if (errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors);
        end
        test_errors_start = error_count;
    endtask

    // drive one cycle of inputs and update the model in read-first order
    task automatic drive_and_model(input int op, input pc38_t pc, input fetch_idx_t fetch_idx,
                                   input asid_t asid, input mdp_t mdp);
        logic [7:0] wset;
        logic [7:0] rset;
        logic [2:0] lane;
        wset = hashed_set(pc[10:3], asid);
        rset = hashed_set(fetch_idx, asid);
        lane = pc[2:0];
        read_req_valid     = (op == OP_READ) || (op == OP_BOTH);
        read_req_fetch_idx = fetch_idx;
        read_req_asid      = asid;
        update_valid       = (op == OP_UPDATE) || (op == OP_BOTH);
        update_pc38        = pc;
        update_asid        = asid;
        update_mdp         = mdp;
        if (read_req_valid) begin
            ref_resp = ref_table[rset];
        end
        if (update_valid) begin
            ref_table[wset][int'(lane) * 8 +: 8] = mdp;
        end
    endtask

    task automatic run_checked_cycle(input int op, input pc38_t pc, input fetch_idx_t fetch_idx,
                                     input asid_t asid, input mdp_t mdp, input string what);
        drive_and_model(op, pc, fetch_idx, asid, mdp);
        @(negedge CLK);
        check_value(what, read_resp_mdp_by_lane, ref_resp);
    endtask

    task automatic load_stimulus();
        int         fd;
        int         n;
        int         test_num;
        int         op;
        string      line;
        pc38_t      pc;
        fetch_idx_t fetch_idx;
        asid_t      asid;
        mdp_t       mdp;
        mdpt_set_t  expected;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %h %h %h %h",
                        test_num, op, pc, fetch_idx, asid, mdp, expected);
            if (n != 7) begin
                $display("malformed stimulus line: %s", line);
                error_count++;
                continue;
            end
            stim_test.push_back(test_num);
            stim_op.push_back(op);
            stim_pc.push_back(pc);
            stim_fetch_idx.push_back(fetch_idx);
            stim_asid.push_back(asid);
            stim_mdp.push_back(mdp);
            stim_expected.push_back(expected);
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // main sequence

    initial begin
        logic [31:0] bits;
        pc38_t       rand_pc;
        asid_t       rand_asid;
        mdp_t        rand_mdp;
        int          assert_failures;
        rst = 1'b1;
        drive_and_model(OP_IDLE, '0, '0, '0, '0);
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_errors_start = 0;
        lfsr_state        = 32'ha106;
        ref_resp          = '0;
        foreach (ref_table[i]) begin
            ref_table[i] = 'x;
        end
        load_stimulus();
        line_count  = stim_test.size();
        stim_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        @(negedge CLK);
        check_value("response after reset", read_resp_mdp_by_lane, '0);
        report_test("reset");

        // zero every lane of every set while the response holds
        for (int s = 0; s < MDPT_SETS; s++) begin
            for (int l = 0; l < FETCH_LANES; l++) begin
                run_checked_cycle(OP_UPDATE, pc38_t'({s[7:0], l[2:0]}), '0, '0, '0,
                                  "table clear");
            end
        end
        report_test("table clear");

        for (int i = 0; i < line_count; i++) begin
            if (i > 0 && stim_test[i] != stim_test[i-1]) begin
                report_test($sformatf("stimulus %0d", stim_test[i-1]));
            end
            drive_and_model(stim_op[i], stim_pc[i], stim_fetch_idx[i], stim_asid[i],
                            stim_mdp[i]);
            check_value($sformatf("stimulus entry %0d, model", i + 1), ref_resp,
                        stim_expected[i]);
            @(negedge CLK);
            check_value($sformatf("stimulus entry %0d, dut", i + 1), read_resp_mdp_by_lane,
                        stim_expected[i]);
        end
        if (line_count > 0) begin
            report_test($sformatf("stimulus %0d", stim_test[line_count-1]));
        end

        for (int r = 0; r < RAND_ROUNDS; r++) begin
            draw_bits(16, bits);
            rand_pc = pc38_t'(bits[15:0]);
            draw_bits(9, bits);
            rand_asid = bits[8:0];
            draw_bits(8, bits);
            rand_mdp = bits[7:0];
            run_checked_cycle(OP_UPDATE, rand_pc, '0, rand_asid, rand_mdp, "random update");
            run_checked_cycle(OP_READ, '0, rand_pc[10:3], rand_asid, '0, "random read back");
        end
        report_test("random updates");

        drive_and_model(OP_IDLE, '0, '0, '0, '0);
        assert_failures = i_mdp_predictor.i_mdpt.i_mdpt_properties.failures;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertions failed",
                 test_count, failed_tests, check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // watchdog

    initial begin
        int limit;
        wait (stim_loaded);
        limit = line_count * 4 + RESET_CYCLES + CLEAR_CYCLES + RAND_ROUNDS * 2 + 100;
        repeat (limit) @(posedge CLK);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* sim/mdpt_properties.sv */
// prediction table assertions on lane write enables, update gating and response hold

module mdpt_properties (
    input logic                                                    CLK,
    input logic                                                    rst,
    input logic                                                    read_req_valid,
    input logic                                                    update_valid,
    input logic [corep::FETCH_LANES-1:0][corep::MDPT_ENTRY_BYTES-1:0] wen_byte,
    input corep::mdpt_set_t                                        read_resp_mdp_by_lane
);

    import corep::*;

    // number of failed assertions
    int failures = 0;

    // one bit per lane group
    logic [FETCH_LANES-1:0] lane_en;

    always_comb begin
        for (int l = 0; l < FETCH_LANES; l++) begin
            lane_en[l] = |wen_byte[l];
        end
    end

    // ----------------------------------------------------------------------
    // write enables

    lane_onehot: assert property (@(posedge CLK) disable iff (rst) $onehot0(lane_en))
        else begin
            failures++;
            $error("more than one lane group has its write enable set");
        end

    wen_needs_valid: assert property (@(posedge CLK) disable iff (rst)
        !update_valid |-> wen_byte == '0)
        else begin
            failures++;
            $error("byte enable set without update_valid");
        end

    // ----------------------------------------------------------------------
    // read port

    resp_hold: assert property (@(posedge CLK) disable iff (rst)
        !read_req_valid |=> $stable(read_resp_mdp_by_lane))
        else begin
            failures++;
            $error("response changed after a cycle with no read request");
        end

endmodule

bind mdpt mdpt_properties i_mdpt_properties (
    .CLK                   (CLK),
    .rst                   (rst),
    .read_req_valid        (read_req_valid),
    .update_valid          (update_valid),
    .wen_byte              (mdpt_array_bram_wen_byte),
    .read_resp_mdp_by_lane (read_resp_mdp_by_lane)
);

/* design/mdp_predictor.sv */
// memory dependence predictor top level: prediction table instance

module mdp_predictor (
    // seq
    input  logic               CLK,
    input  logic               rst,

    // read request from fetch
    input  logic               read_req_valid,
    input  corep::fetch_idx_t  read_req_fetch_idx,
    input  corep::asid_t       read_req_asid,

    // predictions for the whole fetch block
    output corep::mdpt_set_t   read_resp_mdp_by_lane,

    // training update
    input  logic               update_valid,
    input  corep::pc38_t       update_pc38,
    input  corep::asid_t       update_asid,
    input  corep::mdp_t        update_mdp
);

    // ------------------------------------------------------------------
    // prediction table, no extra stages

    mdpt i_mdpt (
        .CLK                   (CLK),
        .rst                   (rst),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_idx    (read_req_fetch_idx),
        .read_req_asid         (read_req_asid),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (update_valid),
        .update_pc38           (update_pc38),
        .update_asid           (update_asid),
        .update_mdp            (update_mdp)
    );

endmodule

/* design/mdpt.sv */
// memory dependence prediction table: index hash, update lane enables, set ram

module mdpt (
    // seq
    input  logic               CLK,
    input  logic               rst,

    // read request
    input  logic               read_req_valid,
    input  corep::fetch_idx_t  read_req_fetch_idx,
    input  corep::asid_t       read_req_asid,

    // read response, one cycle after the request
    output corep::mdpt_set_t   read_resp_mdp_by_lane,

    // update
    input  logic               update_valid,
    input  corep::pc38_t       update_pc38,
    input  corep::asid_t       update_asid,
    input  corep::mdp_t        update_mdp
);

    import corep::*;

    // ------------------------------------------------------------------
    // index hash, shared by read and update

    // fetch index xor low asid bits
    function automatic mdpt_idx_t index_hash(input fetch_idx_t fetch_idx, input asid_t asid);
        return mdpt_idx_t'(fetch_idx) ^ asid[MDPT_IDX_BITS-1:0];
    endfunction

    // ------------------------------------------------------------------
    // signals

    // ram read side
    logic       mdpt_array_bram_ren;
    mdpt_idx_t  mdpt_array_bram_rindex;
    mdpt_set_t  mdpt_array_bram_rdata;

    // ram write side, enables grouped by lane
    logic [FETCH_LANES-1:0][MDPT_ENTRY_BYTES-1:0] mdpt_array_bram_wen_byte;
    mdpt_idx_t                                    mdpt_array_bram_windex;
    mdpt_set_t                                    mdpt_array_bram_wdata;

    // update pc fields
    fetch_lane_t update_lane;
    fetch_idx_t  update_fetch_idx;

    // ------------------------------------------------------------------
    // read side

    always_comb begin
        mdpt_array_bram_ren    = read_req_valid;
        mdpt_array_bram_rindex = index_hash(read_req_fetch_idx, read_req_asid);
    end

    assign read_resp_mdp_by_lane = mdpt_array_bram_rdata;

    // ------------------------------------------------------------------
    // update side

    always_comb begin
        update_lane      = fetch_lane_bits(update_pc38);
        update_fetch_idx = fetch_idx_bits(update_pc38);

        mdpt_array_bram_windex = index_hash(update_fetch_idx, update_asid);

        // only the selected lane is written
        mdpt_array_bram_wen_byte = '0;
        if (update_valid) begin
            mdpt_array_bram_wen_byte[update_lane] = '1;
        end

        // same byte in every lane, the enables pick one
        for (int lane = 0; lane < FETCH_LANES; lane++) begin
            mdpt_array_bram_wdata[lane] = update_mdp;
        end
    end

    // ------------------------------------------------------------------
    // set storage

    bram_1rport_1wport #(
        .INNER_WIDTH ($bits(mdpt_set_t)),
        .OUTER_WIDTH (MDPT_SETS)
    ) mdpt_array_bram (
        .CLK      (CLK),
        .rst      (rst),
        .ren      (mdpt_array_bram_ren),
        .rindex   (mdpt_array_bram_rindex),
        .rdata    (mdpt_array_bram_rdata),
        .wen_byte (mdpt_array_bram_wen_byte),
        .windex   (mdpt_array_bram_windex),
        .wdata    (mdpt_array_bram_wdata)
    );

endmodule

/* design/bram_1rport_1wport.sv */
// block ram with one registered read-first read port and one byte-enabled write port

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 64,
    parameter int OUTER_WIDTH = 256
) (
    // seq
    input  logic                           CLK,
    input  logic                           rst,

    // read port, data one cycle after ren
    input  logic                           ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    // write port, one enable per byte
    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    // ------------------------------------------------------------------
    // storage

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ------------------------------------------------------------------
    // write port

    // only bytes with their enable set change
    always_ff @(posedge CLK) begin
        for (int b = 0; b < INNER_WIDTH/8; b++) begin
            if (wen_byte[b]) begin
                mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------------
    // read port

    // samples the array before this edge's write lands
    // holds its value on cycles without ren
    always_ff @(posedge CLK) begin
        if (rst) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

/* design/corep_pkg.sv */
// core package: fetch, asid and pc sizes, table types, pc field extraction functions

package corep;

    // ------------------------------------------------------------------
    // fetch block and address sizes

    localparam int FETCH_LANES     = 8;
    localparam int FETCH_LANE_BITS = $clog2(FETCH_LANES);
    localparam int FETCH_IDX_BITS  = 8;
    localparam int ASID_BITS       = 9;
    localparam int PC38_BITS       = 38;

    typedef logic [FETCH_LANE_BITS-1:0] fetch_lane_t;
    typedef logic [FETCH_IDX_BITS-1:0]  fetch_idx_t;
    typedef logic [ASID_BITS-1:0]       asid_t;

    // instruction address with the low two bits dropped
    typedef logic [PC38_BITS-1:0]       pc38_t;

    // ------------------------------------------------------------------
    // memory dependence prediction table

    localparam int MDPT_SETS     = 256;
    localparam int MDPT_IDX_BITS = $clog2(MDPT_SETS);
    localparam int MDP_BITS      = 8;

    typedef logic [MDPT_IDX_BITS-1:0] mdpt_idx_t;
    typedef logic [MDP_BITS-1:0]      mdp_t;

    // one entry is just the prediction byte for now
    typedef mdp_t mdpt_entry_t;

    // lane 0 sits in the low byte
    typedef mdpt_entry_t [FETCH_LANES-1:0] mdpt_set_t;

    // byte enables needed per entry in the set word
    localparam int MDPT_ENTRY_BYTES = $bits(mdpt_entry_t) / 8;

    // ------------------------------------------------------------------
    // pc field extraction

    // lane within the fetch block
    function automatic fetch_lane_t fetch_lane_bits(input pc38_t pc38);
        return pc38[FETCH_LANE_BITS-1:0];
    endfunction

    // fetch block index, just above the lane bits
    function automatic fetch_idx_t fetch_idx_bits(input pc38_t pc38);
        return pc38[FETCH_LANE_BITS +: FETCH_IDX_BITS];
    endfunction

endpackage
